// ==== common/mq_cfg_pkg.sv ====
// Sizing constants for the multi-queue buffer, referenced by scoped name from RTL and testbench.
package mq_cfg_pkg;

  // Queue set.
  localparam int NUMQPRT = 8;
  localparam int BITQPRT = 3;

  // Shared entry pool, used by both the data RAM and the link RAM.
  localparam int NUMADDR = 64;
  localparam int BITADDR = 6;

  // A single queue may hold every entry, so the count needs one bit more than a pointer.
  localparam int BITQCNT = BITADDR + 1;

  localparam int WIDTH = 16; // Payload word.

endpackage

// ==== common/mq_types_pkg.sv ====
// Data types of the multi-queue buffer, sized from mq_cfg_pkg; used by every RTL module.
package mq_types_pkg;

  typedef logic [mq_cfg_pkg::BITADDR-1:0] qptr_t; // Entry pointer.

  typedef logic [mq_cfg_pkg::BITQPRT-1:0] qprt_t; // Queue index.

  typedef logic [mq_cfg_pkg::BITQCNT-1:0] qcnt_t; // Occupancy count.

  typedef logic [mq_cfg_pkg::WIDTH-1:0] qdata_t; // Payload word.

  // Reply of the control port.
  // Count sits in the upper bits, followed by head and then tail.
  typedef struct packed {
    qcnt_t cnt;
    qptr_t head;
    qptr_t tail;
  } cp_word_t;

  // Controller phases.
  typedef enum logic [1:0] {
    INIT,
    IDLE,
    POP_WAIT
  } ctrl_state_t;

endpackage

// ==== source/mq_ram.sv ====
// Simple dual-port RAM with one write port and a registered read; payload type set per instance.
module mq_ram #(
  parameter type payload_t = mq_types_pkg::qdata_t
) (
  input  logic                clk,
  input  logic                wr_en,
  input  mq_types_pkg::qptr_t wr_addr,
  input  payload_t            wr_data,
  input  mq_types_pkg::qptr_t rd_addr,
  output payload_t            rd_data
);

  payload_t mem [mq_cfg_pkg::NUMADDR];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read-first. A write to the same address lands after this read.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== source/mq_init_counter.sv ====
// Address sweep used to load every entry into the free list after reset.
module mq_init_counter (
  input  logic                clk,
  input  logic                rst,
  input  logic                init_en,
  output mq_types_pkg::qptr_t init_ptr,
  output logic                init_last
);

  localparam mq_types_pkg::qptr_t LAST_PTR = mq_types_pkg::qptr_t'(mq_cfg_pkg::NUMADDR - 1);

  assign init_last = (init_ptr == LAST_PTR);

  // The pointer wraps back to zero after the last entry, which also drops init_last.
  always_ff @(posedge clk) begin
    if (rst) begin
      init_ptr <= '0;
    end else if (init_en) begin
      init_ptr <= init_ptr + 1'b1;
    end
  end

endmodule

// ==== source/mq_ctrl_fsm.sv ====
// Buffer controller; sequences init, idle and pop-wait phases and grants push and pop requests.
module mq_ctrl_fsm (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic pop,
  input  logic init_last,
  input  logic free_empty,
  output logic init_en,
  output logic push_go,
  output logic pop_go,
  output logic pop_done,
  output logic push_rdy,
  output logic pop_rdy,
  output logic ready
);

  mq_types_pkg::ctrl_state_t state;
  mq_types_pkg::ctrl_state_t state_nxt;
  logic                      in_idle;

  assign in_idle = (state == mq_types_pkg::IDLE);

  assign init_en  = (state == mq_types_pkg::INIT);
  assign pop_done = (state == mq_types_pkg::POP_WAIT);
  assign ready    = in_idle;

  // Pop wins over push, so a push never writes the link a pop is reading.
  assign pop_rdy  = in_idle;
  assign push_rdy = in_idle && !free_empty && !pop;

  assign pop_go  = pop && pop_rdy;
  assign push_go = push && push_rdy;

  always_comb begin
    state_nxt = state;
    case (state)
      mq_types_pkg::INIT: begin
        if (init_last) begin
          state_nxt = mq_types_pkg::IDLE; // Free list is full.
        end
      end
      mq_types_pkg::IDLE: begin
        if (pop_go) begin
          state_nxt = mq_types_pkg::POP_WAIT;
        end
      end
      mq_types_pkg::POP_WAIT: begin
        state_nxt = mq_types_pkg::IDLE;
      end
      default: begin
        state_nxt = mq_types_pkg::INIT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mq_types_pkg::INIT;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== queue_engine/mq_queue_table.sv ====
// Per-queue head, tail and count state; drives link writes on push and serves the control port.
module mq_queue_table (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push_go,
  input  mq_types_pkg::qprt_t    pu_prt,
  input  mq_types_pkg::qptr_t    new_ptr,
  input  logic                   pop_go,
  input  mq_types_pkg::qprt_t    po_prt,
  input  logic                   pop_done,
  input  mq_types_pkg::qptr_t    link_next,
  input  logic                   cp_read,
  input  mq_types_pkg::qprt_t    cp_adr,
  output mq_types_pkg::qptr_t    head_ptr,
  output logic                   link_wr,
  output mq_types_pkg::qptr_t    link_addr,
  output mq_types_pkg::qptr_t    link_data,
  output mq_types_pkg::qptr_t    released_ptr,
  output logic                   cp_vld,
  output mq_types_pkg::cp_word_t cp_dout
);

  mq_types_pkg::qptr_t head [mq_cfg_pkg::NUMQPRT];
  mq_types_pkg::qptr_t tail [mq_cfg_pkg::NUMQPRT];
  mq_types_pkg::qcnt_t q_cnt [mq_cfg_pkg::NUMQPRT];
  mq_types_pkg::qprt_t pop_prt_q;
  mq_types_pkg::qptr_t pop_ptr_q;
  logic                pu_empty;

  assign pu_empty = (q_cnt[pu_prt] == '0);

  // Both RAMs are read at the head of the queue being popped.
  assign head_ptr = head[po_prt];

  // Chain the new entry behind the old tail, unless the queue had none.
  assign link_wr   = push_go && !pu_empty;
  assign link_addr = tail[pu_prt];
  assign link_data = new_ptr;

  assign released_ptr = pop_ptr_q; // Handed back to the free list in POP_WAIT.

  always_ff @(posedge clk) begin
    if (pop_go) begin
      pop_prt_q <= po_prt;
      pop_ptr_q <= head_ptr;
    end
  end

  // Pushes are never granted in POP_WAIT, so the two updates never meet.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int q = 0; q < mq_cfg_pkg::NUMQPRT; q++) begin
        head[q]  <= '0;
        tail[q]  <= '0;
        q_cnt[q] <= '0;
      end
    end else begin
      if (pop_done) begin
        head[pop_prt_q]  <= link_next; // Link RAM output holds the successor.
        q_cnt[pop_prt_q] <= q_cnt[pop_prt_q] - 1'b1;
      end
      if (push_go) begin
        tail[pu_prt]  <= new_ptr;
        q_cnt[pu_prt] <= q_cnt[pu_prt] + 1'b1;
        if (pu_empty) begin
          head[pu_prt] <= new_ptr;
        end
      end
    end
  end

  // Control-port reply, one cycle after the request.
  always_ff @(posedge clk) begin
    if (rst) begin
      cp_vld <= 1'b0;
    end else begin
      cp_vld <= cp_read;
    end
  end

  always_ff @(posedge clk) begin
    if (cp_read) begin
      cp_dout.cnt  <= q_cnt[cp_adr];
      cp_dout.head <= head[cp_adr];
      cp_dout.tail <= tail[cp_adr];
    end
  end

endmodule

// ==== queue_engine/mq_free_list.sv ====
// Circular FIFO of unused entry pointers; loaded during init, drained by pushes, refilled by pops.
module mq_free_list (
  input  logic                clk,
  input  logic                rst,
  input  logic                init_wr,
  input  mq_types_pkg::qptr_t init_ptr,
  input  logic                alloc,
  input  logic                release_en,
  input  mq_types_pkg::qptr_t release_ptr,
  output mq_types_pkg::qptr_t free_ptr,
  output logic                free_empty
);

  mq_types_pkg::qptr_t ptr_mem [mq_cfg_pkg::NUMADDR];
  mq_types_pkg::qptr_t rd_idx;
  mq_types_pkg::qptr_t wr_idx;
  mq_types_pkg::qcnt_t free_cnt;
  logic                wr_go;

  assign wr_go      = init_wr || release_en;
  assign free_ptr   = ptr_mem[rd_idx]; // Next entry to hand out.
  assign free_empty = (free_cnt == '0);

  always_ff @(posedge clk) begin
    if (wr_go) begin
      ptr_mem[wr_idx] <= init_wr ? init_ptr : release_ptr;
    end
  end

  // The indices wrap naturally since the depth is a power of two.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_idx   <= '0;
      wr_idx   <= '0;
      free_cnt <= '0;
    end else begin
      if (wr_go) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (alloc) begin
        rd_idx <= rd_idx + 1'b1;
      end
      case ({wr_go, alloc})
        2'b10:   free_cnt <= free_cnt + 1'b1;
        2'b01:   free_cnt <= free_cnt - 1'b1;
        default: free_cnt <= free_cnt;
      endcase
    end
  end

endmodule

// ==== source/mq_buffer.sv ====
// Top level of the linked-list multi-queue packet buffer; instantiate this as the DUT.
module mq_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  mq_types_pkg::qprt_t    pu_prt,
  input  mq_types_pkg::qdata_t   pu_din,
  output logic                   push_rdy,
  input  logic                   pop,
  input  mq_types_pkg::qprt_t    po_prt,
  output logic                   pop_rdy,
  output logic                   po_vld,
  output mq_types_pkg::qdata_t   po_dout,
  input  logic                   cp_read,
  input  mq_types_pkg::qprt_t    cp_adr,
  output logic                   cp_vld,
  output mq_types_pkg::cp_word_t cp_dout,
  output logic                   ready
);

  logic                init_en;
  logic                init_last;
  mq_types_pkg::qptr_t init_ptr;
  logic                push_go;
  logic                pop_go;
  logic                pop_done;
  mq_types_pkg::qptr_t free_ptr;
  logic                free_empty;
  mq_types_pkg::qptr_t head_ptr;
  logic                link_wr;
  mq_types_pkg::qptr_t link_addr;
  mq_types_pkg::qptr_t link_data;
  mq_types_pkg::qptr_t link_next;
  mq_types_pkg::qptr_t released_ptr;

  assign po_vld = pop_done; // Data RAM output is valid during POP_WAIT.

  mq_ctrl_fsm mq_ctrl_fsm_inst (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .pop        (pop),
    .init_last  (init_last),
    .free_empty (free_empty),
    .init_en    (init_en),
    .push_go    (push_go),
    .pop_go     (pop_go),
    .pop_done   (pop_done),
    .push_rdy   (push_rdy),
    .pop_rdy    (pop_rdy),
    .ready      (ready)
  );

  mq_init_counter mq_init_counter_inst (
    .clk       (clk),
    .rst       (rst),
    .init_en   (init_en),
    .init_ptr  (init_ptr),
    .init_last (init_last)
  );

  // Payload storage, written at the allocated entry.
  mq_ram #(.payload_t(mq_types_pkg::qdata_t)) data_ram_inst (
    .clk     (clk),
    .wr_en   (push_go),
    .wr_addr (free_ptr),
    .wr_data (pu_din),
    .rd_addr (head_ptr),
    .rd_data (po_dout)
  );

  // Next-entry pointers that chain each queue together.
  mq_ram #(.payload_t(mq_types_pkg::qptr_t)) link_ram_inst (
    .clk     (clk),
    .wr_en   (link_wr),
    .wr_addr (link_addr),
    .wr_data (link_data),
    .rd_addr (head_ptr),
    .rd_data (link_next)
  );

  mq_queue_table mq_queue_table_inst (
    .clk          (clk),
    .rst          (rst),
    .push_go      (push_go),
    .pu_prt       (pu_prt),
    .new_ptr      (free_ptr),
    .pop_go       (pop_go),
    .po_prt       (po_prt),
    .pop_done     (pop_done),
    .link_next    (link_next),
    .cp_read      (cp_read),
    .cp_adr       (cp_adr),
    .head_ptr     (head_ptr),
    .link_wr      (link_wr),
    .link_addr    (link_addr),
    .link_data    (link_data),
    .released_ptr (released_ptr),
    .cp_vld       (cp_vld),
    .cp_dout      (cp_dout)
  );

  mq_free_list mq_free_list_inst (
    .clk         (clk),
    .rst         (rst),
    .init_wr     (init_en),
    .init_ptr    (init_ptr),
    .alloc       (push_go),
    .release_en  (pop_done),
    .release_ptr (released_ptr),
    .free_ptr    (free_ptr),
    .free_empty  (free_empty)
  );

endmodule

// ==== tb/mq_clk_gen.sv ====
// Testbench clock and reset source for the mq_buffer testbench; 100-unit period, 4-cycle reset.
module mq_clk_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0; // Released on a rising edge like every other input.
  end

endmodule

// ==== tb/mq_buffer_chk.sv ====
// Concurrent protocol assertions for mq_buffer; attached to the DUT by bind from the testbench.
module mq_buffer_chk (
  input logic                clk,
  input logic                rst,
  input logic                push,
  input logic                pop,
  input logic                pop_rdy,
  input logic                po_vld,
  input logic                push_rdy,
  input logic                ready,
  input mq_types_pkg::qcnt_t pop_cnt
);

  int assert_fail_cnt = 0; // Read by the testbench at the end of the run.
  int in_use;              // Entries held by all queues, counted at the ports.

  always_ff @(posedge clk) begin
    if (rst) begin
      in_use <= 0;
    end else if (push && push_rdy) begin
      in_use <= in_use + 1;
    end else if (po_vld) begin
      in_use <= in_use - 1;
    end
  end

  // The environment must never pop a queue that holds nothing.
  pop_not_empty: assert property (@(posedge clk) disable iff (rst)
    (pop && pop_rdy) |-> (pop_cnt != '0))
    else begin
      assert_fail_cnt++;
      $error("A pop was accepted on an empty queue.");
    end

  pop_data_next: assert property (@(posedge clk) disable iff (rst)
    (pop && pop_rdy) |=> po_vld)
    else begin
      assert_fail_cnt++;
      $error("po_vld did not follow an accepted pop.");
    end

  // Once every entry sits in a queue the free list has nothing left to hand out.
  no_push_when_full: assert property (@(posedge clk) disable iff (rst)
    (in_use == mq_cfg_pkg::NUMADDR) |-> !push_rdy)
    else begin
      assert_fail_cnt++;
      $error("push_rdy was high while the free list was empty.");
    end

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!ready && !push_rdy && !pop_rdy))
    else begin
      assert_fail_cnt++;
      $error("A grant or ready was high in the cycle after reset.");
    end

endmodule

// ==== tb/mq_buffer_tb.sv ====
// Self-checking testbench for mq_buffer; runs the command list in tb/mq_buffer_stimulus.txt.
module mq_buffer_tb;

  localparam int MAX_STEPS  = 64;
  localparam int TIMEOUT    = 200; // Longest wait for any handshake, in cycles.
  localparam int REFUSE_CYC = 4;   // A fill stops once push_rdy stays low this long.

  logic                   clk;
  logic                   rst;
  logic                   push;
  mq_types_pkg::qprt_t    pu_prt;
  mq_types_pkg::qdata_t   pu_din;
  logic                   push_rdy;
  logic                   pop;
  mq_types_pkg::qprt_t    po_prt;
  logic                   pop_rdy;
  logic                   po_vld;
  mq_types_pkg::qdata_t   po_dout;
  logic                   cp_read;
  mq_types_pkg::qprt_t    cp_adr;
  logic                   cp_vld;
  mq_types_pkg::cp_word_t cp_dout;
  logic                   ready;
  logic [39:0]            stim [MAX_STEPS];
  int                     pass_cnt;
  int                     fail_cnt;
  mq_types_pkg::qptr_t    free_model [$];                       // Free entries in hand-out order.
  mq_types_pkg::qptr_t    queue_model [mq_cfg_pkg::NUMQPRT][$]; // Entries of a queue, oldest first.

  mq_clk_gen mq_clk_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  mq_buffer mq_buffer_inst (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .pu_prt   (pu_prt),
    .pu_din   (pu_din),
    .push_rdy (push_rdy),
    .pop      (pop),
    .po_prt   (po_prt),
    .pop_rdy  (pop_rdy),
    .po_vld   (po_vld),
    .po_dout  (po_dout),
    .cp_read  (cp_read),
    .cp_adr   (cp_adr),
    .cp_vld   (cp_vld),
    .cp_dout  (cp_dout),
    .ready    (ready)
  );

  bind mq_buffer mq_buffer_chk mq_buffer_chk_inst (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .pop        (pop),
    .pop_rdy    (pop_rdy),
    .po_vld     (po_vld),
    .push_rdy   (push_rdy),
    .ready      (ready),
    .pop_cnt    (mq_queue_table_inst.q_cnt[po_prt])
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  function automatic logic level(input int sel);
    case (sel)
      0: return ready;
      1: return push_rdy;
      2: return pop_rdy;
      3: return po_vld;
      default: return cp_vld;
    endcase
  endfunction

  // Outputs are looked at on the falling edge, where they have settled.
  task automatic wait_high(input int sel, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!level(sel) && cycles < TIMEOUT);
    if (!level(sel)) begin
      abort_run($sformatf("Timed out after %0d cycles waiting for %s.", TIMEOUT, what));
    end
  endtask

  // An entry leaves the free list at its head and joins the tail of queue q.
  function automatic void alloc_entry(input mq_types_pkg::qprt_t q);
    if (free_model.size() > 0) begin
      queue_model[q].push_back(free_model.pop_front());
    end
  endfunction

  // A popped entry goes back to the tail of the free list.
  function automatic void release_entry(input mq_types_pkg::qprt_t q);
    if (queue_model[q].size() > 0) begin
      free_model.push_back(queue_model[q].pop_front());
    end
  endfunction

  task automatic push_word(input mq_types_pkg::qprt_t q, input mq_types_pkg::qdata_t d);
    @(posedge clk);
    push   <= 1'b1;
    pu_prt <= q;
    pu_din <= d;
    wait_high(1, "push_rdy");
    @(posedge clk); // The push is taken at this edge.
    push <= 1'b0;
  endtask

  task automatic pop_word(input mq_types_pkg::qprt_t q, output mq_types_pkg::qdata_t d);
    @(posedge clk);
    pop    <= 1'b1;
    po_prt <= q;
    wait_high(2, "pop_rdy");
    @(posedge clk);
    pop <= 1'b0;
    wait_high(3, "po_vld");
    d = po_dout;
  endtask

  task automatic read_queue_state(input mq_types_pkg::qprt_t q,
                                  output mq_types_pkg::cp_word_t word);
    @(posedge clk);
    cp_read <= 1'b1;
    cp_adr  <= q;
    @(posedge clk);
    cp_read <= 1'b0;
    wait_high(4, "cp_vld");
    word = cp_dout;
  endtask

  // Pushes base, base+1 and so on into one queue until the free list runs dry.
  task automatic fill_queue(input mq_types_pkg::qprt_t q, input mq_types_pkg::qdata_t base,
                            output int accepted);
    int idle;
    accepted = 0;
    idle     = 0;
    @(posedge clk);
    push   <= 1'b1;
    pu_prt <= q;
    pu_din <= base;
    while (idle < REFUSE_CYC && accepted <= mq_cfg_pkg::NUMADDR) begin
      @(negedge clk);
      if (push_rdy) begin
        accepted++;
        idle = 0;
      end else begin
        idle++;
      end
      @(posedge clk);
      pu_din <= base + mq_types_pkg::qdata_t'(accepted);
    end
    push <= 1'b0;
  endtask

  task automatic note_pass(input string name);
    pass_cnt++;
    $display("ok       %s", name);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) begin
      note_pass(name);
    end else begin
      fail_cnt++;
      $display("** Error: %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  initial begin
    int                     step;
    int                     cnt;
    int                     chk_fails;
    logic                   done;
    logic [3:0]             op;
    logic [3:0]             qf;
    logic [15:0]            data;
    logic [15:0]            exp;
    mq_types_pkg::qdata_t   got;
    mq_types_pkg::cp_word_t reply;
    string                  name;
    push     = 1'b0;
    pu_prt   = '0;
    pu_din   = '0;
    pop      = 1'b0;
    po_prt   = '0;
    cp_read  = 1'b0;
    cp_adr   = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    for (int i = 0; i < mq_cfg_pkg::NUMADDR; i++) begin
      free_model.push_back(mq_types_pkg::qptr_t'(i)); // Init loads entries in address order.
    end
    $readmemh("tb/mq_buffer_stimulus.txt", stim);
    wait_high(0, "ready after reset");
    step = 0;
    done = 1'b0;
    while (!done && step < MAX_STEPS) begin
      {op, qf, data, exp} = stim[step];
      name = $sformatf("step %0d q%0d", step, qf[2:0]);
      case (op)
        4'h0: done = 1'b1;
        4'h1: begin
          push_word(qf[2:0], data);
          alloc_entry(qf[2:0]);
          note_pass({"push ", name});
        end
        4'h2: begin
          pop_word(qf[2:0], got);
          release_entry(qf[2:0]);
          check_value({"pop ", name}, exp, got);
        end
        4'h3: begin
          read_queue_state(qf[2:0], reply);
          if (queue_model[qf[2:0]].size() > 0) begin
            // A queue with entries also reports its oldest and newest pointer.
            check_value({"count ", name},
                        {exp[mq_cfg_pkg::BITQCNT-1:0], queue_model[qf[2:0]][0],
                         queue_model[qf[2:0]][$]},
                        reply);
          end else begin
            check_value({"count ", name}, exp, reply.cnt);
          end
        end
        4'h4: begin
          fill_queue(qf[2:0], data, cnt);
          repeat (cnt) alloc_entry(qf[2:0]);
          check_value({"fill ", name}, exp, cnt);
        end
        default: begin
          fail_cnt++;
          $display("Step %0d holds an unknown opcode %h.", step, op);
          done = 1'b1;
        end
      endcase
      step++;
    end
    chk_fails = mq_buffer_inst.mq_buffer_chk_inst.assert_fail_cnt;
    $display("Tests: %0d passed, %0d failed, %0d assertion failures.",
             pass_cnt, fail_cnt, chk_fails);
    if (fail_cnt == 0 && chk_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/mq_buffer_stimulus.txt ====
// Columns: opcode, queue, data, expected. Opcodes: 0 end, 1 push data, 2 pop and expect data,
// 3 read count and expect it, 4 push data upward until refused and expect the accepted count.
3_0_0000_0000
3_1_0000_0000
3_2_0000_0000
3_3_0000_0000
3_4_0000_0000
3_5_0000_0000
3_6_0000_0000
3_7_0000_0000
1_1_a101_0000
1_1_a102_0000
1_1_a103_0000
1_1_a104_0000
3_1_0000_0004
2_1_0000_a101
2_1_0000_a102
2_1_0000_a103
2_1_0000_a104
1_0_b001_0000
1_3_c001_0000
1_7_d001_0000
1_0_b002_0000
1_3_c002_0000
1_7_d002_0000
3_3_0000_0002
3_7_0000_0002
2_3_0000_c001
2_0_0000_b001
2_7_0000_d001
2_3_0000_c002
3_0_0000_0001
3_3_0000_0000
2_0_0000_b002
2_7_0000_d002
4_2_2000_0040
3_2_0000_0040
2_2_0000_2000
2_2_0000_2001
2_2_0000_2002
2_2_0000_2003
2_2_0000_2004
2_2_0000_2005
2_2_0000_2006
2_2_0000_2007
2_2_0000_2008
2_2_0000_2009
4_6_6000_000a
3_6_0000_000a
3_2_0000_0036
2_6_0000_6000
2_6_0000_6001
2_2_0000_200a
0_0_0000_0000

// ==== mq_buffer.f ====
common/mq_cfg_pkg.sv
common/mq_types_pkg.sv
source/mq_ram.sv
source/mq_init_counter.sv
source/mq_ctrl_fsm.sv
queue_engine/mq_queue_table.sv
queue_engine/mq_free_list.sv
source/mq_buffer.sv
tb/mq_clk_gen.sv
tb/mq_buffer_chk.sv
tb/mq_buffer_tb.sv
